/* fbc_cfg_pkg.sv */
// link configuration constants
package fbc_cfg_pkg;

	// endpoint addresses
	localparam logic [7:0] ep_cmd_addr     = 8'h01;
	localparam logic [7:0] ep_status_addr  = 8'h20;
	localparam logic [7:0] ep_rxdata_addr  = 8'h21;
	localparam logic [7:0] ep_txcount_addr = 8'h22;
	localparam logic [7:0] ep_rxcount_addr = 8'h23;
	localparam logic [7:0] ep_trig_addr    = 8'h40;

	// bits of the trigger-in word
	localparam int trig_exec_bit  = 0;
	localparam int trig_pop_bit   = 1;
	localparam int trig_clear_bit = 2;

	// status word layout, queue count sits in 11:8
	localparam int st_bt_state_bit    = 0;
	localparam int st_enable_bit      = 1;
	localparam int st_tx_busy_bit     = 2;
	localparam int st_rx_avail_bit    = 3;
	localparam int st_tx_overrun_bit  = 4;
	localparam int st_rx_overflow_bit = 5;
	localparam int st_frame_err_bit   = 6;

	localparam int ep_width = 16;

	// serial timing, short bit period for simulation
	localparam int clks_per_bit   = 8;
	localparam int half_bit       = clks_per_bit / 2;
	localparam int baud_cnt_width = $clog2(clks_per_bit);

	// receive queue sizing
	localparam int rxq_depth       = 8;
	localparam int rxq_count_width = 4;
	localparam int rxq_ptr_width   = $clog2(rxq_depth);

endpackage

/* fbc_cmd_pkg.sv */
// host command word views
package fbc_cmd_pkg;

	// command kind in bit 15 of the word
	typedef enum logic {
		cmd_send = 1'b0,
		cmd_ctrl = 1'b1
	} cmd_kind_t;

	// send a byte over the serial link
	typedef struct packed {
		cmd_kind_t  kind;
		logic [6:0] rsvd;
		logic [7:0] data;
	} send_view_t;

	// drive the module enable pin
	typedef struct packed {
		cmd_kind_t   kind;
		logic [13:0] rsvd;
		logic        enable;
	} ctrl_view_t;

	typedef union packed {
		send_view_t send;
		ctrl_view_t ctrl;
	} host_cmd_u;

endpackage

/* uart_tx.sv */
// serial transmitter 8N1
`timescale 1ns/1ns

module uart_tx import fbc_cfg_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy,
	output logic       txd
);

	logic [baud_cnt_width-1:0] baud_cnt;
	logic [3:0]                bit_idx;
	logic [8:0]                shifter;
	logic                      bit_end;

	assign bit_end = (baud_cnt == baud_cnt_width'(clks_per_bit - 1));

	// bit_idx 0 is the start bit, 9 the stop bit
	always_ff @(posedge clock) begin
		if (rst) begin
			tx_busy  <= 1'b0;
			txd      <= 1'b1;
			baud_cnt <= '0;
			bit_idx  <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy  <= 1'b1;
				txd      <= 1'b0;
				baud_cnt <= '0;
				bit_idx  <= '0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0;
				txd     <= 1'b1;
			end else begin
				txd     <= shifter[0];
				bit_idx <= bit_idx + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// data bits lsb first, then the stop bit shifts in from the top
	always_ff @(posedge clock) begin
		if (!tx_busy && tx_start)
			shifter <= {1'b1, tx_byte};
		else if (tx_busy && bit_end)
			shifter <= {1'b1, shifter[8:1]};
	end

endmodule

/* uart_rx.sv */
// serial receiver 8N1
`timescale 1ns/1ns

module uart_rx import fbc_cfg_pkg::*; (
	input  logic       clock,
	input  logic       rst,
	input  logic       rxd,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	output logic       rx_frame_err
);

	logic                      rxd_meta;
	logic                      rxd_sync;
	logic                      rxd_prev;
	logic                      active;
	logic [3:0]                bit_idx;
	logic [baud_cnt_width-1:0] baud_cnt;
	logic [7:0]                shifter;
	logic                      mid_start;
	logic                      bit_end;

	assign mid_start = (baud_cnt == baud_cnt_width'(half_bit - 1));
	assign bit_end   = (baud_cnt == baud_cnt_width'(clks_per_bit - 1));

	// line idles high
	always_ff @(posedge clock) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	// bit_idx 0 checks the start bit, 1..8 data, 9 stop
	always_ff @(posedge clock) begin
		if (rst) begin
			active   <= 1'b0;
			bit_idx  <= '0;
			baud_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!active) begin
				if (rxd_prev && !rxd_sync) begin
					active   <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= '0;
				end
			end else if (bit_idx == 4'd0) begin
				if (mid_start) begin
					baud_cnt <= '0;
					// glitch, line back high before mid start bit
					if (rxd_sync)
						active <= 1'b0;
					else
						bit_idx <= 4'd1;
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_idx == 4'd9) begin
					active   <= 1'b0;
					rx_valid <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (active && bit_idx != 4'd0 && bit_end) begin
			if (bit_idx == 4'd9) begin
				rx_byte      <= shifter;
				rx_frame_err <= !rxd_sync;
			end else begin
				shifter <= {rxd_sync, shifter[7:1]};
			end
		end
	end

endmodule

/* bt_link_ctrl.sv */
// bluetooth link controller
`timescale 1ns/1ns

module bt_link_ctrl import fbc_cfg_pkg::*, fbc_cmd_pkg::*; (
	input  logic                clock,
	input  logic                rst,
	input  logic [ep_width-1:0] cmd_word,
	input  logic                exec_pulse,
	input  logic                pop_pulse,
	input  logic                clear_pulse,
	output logic [ep_width-1:0] status_word,
	output logic [ep_width-1:0] rx_head_word,
	output logic [ep_width-1:0] tx_count,
	output logic [ep_width-1:0] rx_count,
	input  logic                bt_state,
	output logic                bt_enable,
	output logic                fpga_txd,
	input  logic                fpga_rxd
);

	host_cmd_u                  cmd;
	logic                       send_exec;
	logic                       ctrl_exec;
	logic                       tx_start;
	logic                       tx_busy;
	logic                       rx_valid;
	logic                       rx_frame_err;
	logic [7:0]                 rx_byte;
	logic                       state_meta;
	logic                       state_sync;
	logic [7:0]                 rxq_mem [rxq_depth];
	logic [rxq_ptr_width-1:0]   wr_ptr;
	logic [rxq_ptr_width-1:0]   rd_ptr;
	logic [rxq_count_width-1:0] rxq_count;
	logic                       rxq_full;
	logic                       rxq_empty;
	logic                       push;
	logic                       pop;
	logic                       tx_overrun;
	logic                       rx_overflow;
	logic                       frame_err;

	assign cmd       = cmd_word;
	assign send_exec = exec_pulse && (cmd.send.kind == cmd_send);
	assign ctrl_exec = exec_pulse && (cmd.ctrl.kind == cmd_ctrl);
	assign tx_start  = send_exec && !tx_busy;

	assign rxq_full  = (rxq_count == rxq_count_width'(rxq_depth));
	assign rxq_empty = (rxq_count == '0);
	// good frames only
	assign push      = rx_valid && !rx_frame_err && !rxq_full;
	assign pop       = pop_pulse && !rxq_empty;

	always_ff @(posedge clock) begin
		if (rst) begin
			bt_enable   <= 1'b0;
			state_meta  <= 1'b0;
			state_sync  <= 1'b0;
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			rxq_count   <= '0;
			tx_count    <= '0;
			rx_count    <= '0;
			tx_overrun  <= 1'b0;
			rx_overflow <= 1'b0;
			frame_err   <= 1'b0;
		end else begin
			state_meta <= bt_state;
			state_sync <= state_meta;
			if (ctrl_exec)
				bt_enable <= cmd.ctrl.enable;
			if (tx_start)
				tx_count <= tx_count + 1'b1;
			if (push) begin
				wr_ptr   <= wr_ptr + 1'b1;
				rx_count <= rx_count + 1'b1;
			end
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				rxq_count <= rxq_count + 1'b1;
			else if (pop && !push)
				rxq_count <= rxq_count - 1'b1;
			// a new error in the clear cycle still sticks
			if (clear_pulse) begin
				tx_overrun  <= 1'b0;
				rx_overflow <= 1'b0;
				frame_err   <= 1'b0;
			end
			if (send_exec && tx_busy)
				tx_overrun <= 1'b1;
			if (rx_valid && !rx_frame_err && rxq_full)
				rx_overflow <= 1'b1;
			if (rx_valid && rx_frame_err)
				frame_err <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			rxq_mem[wr_ptr] <= rx_byte;
	end

	assign rx_head_word = rxq_empty ? '0 : {7'b0, 1'b1, rxq_mem[rd_ptr]};

	always_comb begin
		status_word                     = '0;
		status_word[st_bt_state_bit]    = state_sync;
		status_word[st_enable_bit]      = bt_enable;
		status_word[st_tx_busy_bit]     = tx_busy;
		status_word[st_rx_avail_bit]    = !rxq_empty;
		status_word[st_tx_overrun_bit]  = tx_overrun;
		status_word[st_rx_overflow_bit] = rx_overflow;
		status_word[st_frame_err_bit]   = frame_err;
		status_word[11:8]               = rxq_count;
	end

	uart_tx tx_i (
		.clock   (clock),
		.rst     (rst),
		.tx_start(tx_start),
		.tx_byte (cmd.send.data),
		.tx_busy (tx_busy),
		.txd     (fpga_txd)
	);

	uart_rx rx_i (
		.clock       (clock),
		.rst         (rst),
		.rxd         (fpga_rxd),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.rx_frame_err(rx_frame_err)
	);

endmodule

/* host_endpoints.sv */
// host endpoint register bus
`timescale 1ns/1ns

module host_endpoints import fbc_cfg_pkg::*; (
	input  logic                clock,
	input  logic                rst,
	input  logic                host_req,
	input  logic                host_we,
	input  logic [7:0]          host_addr,
	input  logic [ep_width-1:0] host_wdata,
	output logic                host_ack,
	output logic [ep_width-1:0] host_rdata,
	output logic [ep_width-1:0] cmd_word,
	output logic                exec_pulse,
	output logic                pop_pulse,
	output logic                clear_pulse,
	input  logic [ep_width-1:0] status_word,
	input  logic [ep_width-1:0] rx_head_word,
	input  logic [ep_width-1:0] tx_count,
	input  logic [ep_width-1:0] rx_count
);

	logic                access;
	logic                trig_write;
	logic [ep_width-1:0] read_mux;

	// first cycle of a request, before ack goes up
	assign access     = host_req && !host_ack;
	assign trig_write = access && host_we && (host_addr == ep_trig_addr);

	// wire-outs only, everything else reads zero
	always_comb begin
		case (host_addr)
			ep_status_addr:  read_mux = status_word;
			ep_rxdata_addr:  read_mux = rx_head_word;
			ep_txcount_addr: read_mux = tx_count;
			ep_rxcount_addr: read_mux = rx_count;
			default:         read_mux = '0;
		endcase
	end

	// four-phase ack
	always_ff @(posedge clock) begin
		if (rst)
			host_ack <= 1'b0;
		else if (access)
			host_ack <= 1'b1;
		else if (!host_req)
			host_ack <= 1'b0;
	end

	// command wire-in
	always_ff @(posedge clock) begin
		if (rst)
			cmd_word <= '0;
		else if (access && host_we && host_addr == ep_cmd_addr)
			cmd_word <= host_wdata;
	end

	// trigger pulses line up with the rising ack
	always_ff @(posedge clock) begin
		if (rst) begin
			exec_pulse  <= 1'b0;
			pop_pulse   <= 1'b0;
			clear_pulse <= 1'b0;
		end else begin
			exec_pulse  <= trig_write && host_wdata[trig_exec_bit];
			pop_pulse   <= trig_write && host_wdata[trig_pop_bit];
			clear_pulse <= trig_write && host_wdata[trig_clear_bit];
		end
	end

	always_ff @(posedge clock) begin
		if (access)
			host_rdata <= host_we ? '0 : read_mux;
	end

endmodule

/* fbc_top.sv */
// bluetooth connection top level
`timescale 1ns/1ns

module fbc_top (
	input  logic        CLK1MHZ,
	input  logic        rst,
	input  logic        host_req,
	input  logic        host_we,
	input  logic [7:0]  host_addr,
	input  logic [15:0] host_wdata,
	output logic        host_ack,
	output logic [15:0] host_rdata,
	input  logic        bt_state,
	output logic        bt_enable,
	output logic        fpga_txd,
	input  logic        fpga_rxd,
	output logic [7:0]  led
);

	logic [15:0] cmd_word;
	logic        exec_pulse;
	logic        pop_pulse;
	logic        clear_pulse;
	logic [15:0] status_word;
	logic [15:0] rx_head_word;
	logic [15:0] tx_count;
	logic [15:0] rx_count;

	// leds are active low
	assign led = ~status_word[7:0];

	host_endpoints endpoints_i (
		.clock       (CLK1MHZ),
		.rst         (rst),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_ack    (host_ack),
		.host_rdata  (host_rdata),
		.cmd_word    (cmd_word),
		.exec_pulse  (exec_pulse),
		.pop_pulse   (pop_pulse),
		.clear_pulse (clear_pulse),
		.status_word (status_word),
		.rx_head_word(rx_head_word),
		.tx_count    (tx_count),
		.rx_count    (rx_count)
	);

	bt_link_ctrl link_i (
		.clock       (CLK1MHZ),
		.rst         (rst),
		.cmd_word    (cmd_word),
		.exec_pulse  (exec_pulse),
		.pop_pulse   (pop_pulse),
		.clear_pulse (clear_pulse),
		.status_word (status_word),
		.rx_head_word(rx_head_word),
		.tx_count    (tx_count),
		.rx_count    (rx_count),
		.bt_state    (bt_state),
		.bt_enable   (bt_enable),
		.fpga_txd    (fpga_txd),
		.fpga_rxd    (fpga_rxd)
	);

endmodule

/* tb_fbc.sv */
// bluetooth link testbench
`timescale 1ns/1ns

module tb_fbc import fbc_cfg_pkg::*; ();

	localparam int bus_timeout   = 40;
	localparam int frame_timeout = 12 * clks_per_bit;
	localparam int n_rx          = 5;

	typedef enum logic [2:0] {
		op_write,
		op_read,
		op_rx,
		op_tx,
		op_state,
		op_pins,
		op_idle,
		op_tx_none
	} op_t;

	// one table row, rx data bit 8 forces a low stop bit
	typedef struct packed {
		op_t         op;
		logic [3:0]  test;
		logic [7:0]  addr;
		logic [15:0] data;
		logic [15:0] exp;
	} step_t;

	logic        clk;
	logic        rst;
	logic        host_req;
	logic        host_we;
	logic [7:0]  host_addr;
	logic [15:0] host_wdata;
	logic        host_ack;
	logic [15:0] host_rdata;
	logic        bt_state;
	logic        bt_enable;
	logic        fpga_txd;
	logic        fpga_rxd;
	logic [7:0]  led;

	step_t      steps[$];
	logic [7:0] tx_seen[$];
	int         errors;
	int         checks;
	int         failed_tests;
	int         cur_test;
	int         build_test;
	int         test_errors[5];
	string      test_name[5];

	fbc_top fbc_top_i (
		.CLK1MHZ   (clk),
		.rst       (rst),
		.host_req  (host_req),
		.host_we   (host_we),
		.host_addr (host_addr),
		.host_wdata(host_wdata),
		.host_ack  (host_ack),
		.host_rdata(host_rdata),
		.bt_state  (bt_state),
		.bt_enable (bt_enable),
		.fpga_txd  (fpga_txd),
		.fpga_rxd  (fpga_rxd),
		.led       (led)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#100000;
		$display("simulation ran past its time limit");
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [15:0] bitval(input int b);
		return 16'h1 << b;
	endfunction

	// expected pins packed as led, txd, enable
	function automatic logic [15:0] pins(input logic en, input logic txd, input logic [7:0] leds);
		return {leds, 6'b0, txd, en};
	endfunction

	task automatic add_step(input op_t op, input logic [7:0] addr, input logic [15:0] data,
			input logic [15:0] exp);
		step_t s;
		s.op   = op;
		s.test = 4'(build_test);
		s.addr = addr;
		s.data = data;
		s.exp  = exp;
		steps.push_back(s);
	endtask

	task automatic note_error();
		errors++;
		test_errors[cur_test]++;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp, input logic [15:0] mask);
		checks++;
		assert ((got & mask) === (exp & mask)) else begin
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got & mask, exp & mask);
			note_error();
		end
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
		int n;
		host_addr  = addr;
		host_wdata = data;
		host_we    = 1'b1;
		host_req   = 1'b1;
		n = 0;
		while (!host_ack && n < bus_timeout) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (host_ack) else begin
			$display("host write to %h got no ack", addr);
			note_error();
		end
		host_req = 1'b0;
		host_we  = 1'b0;
		n = 0;
		while (host_ack && n < bus_timeout) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (!host_ack) else begin
			$display("ack stayed high after a write to %h", addr);
			note_error();
		end
	endtask

	task automatic host_read(input logic [7:0] addr, output logic [15:0] data);
		int n;
		host_addr = addr;
		host_we   = 1'b0;
		host_req  = 1'b1;
		n = 0;
		while (!host_ack && n < bus_timeout) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (host_ack) else begin
			$display("host read from %h got no ack", addr);
			note_error();
		end
		data     = host_rdata;
		host_req = 1'b0;
		n = 0;
		while (host_ack && n < bus_timeout) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (!host_ack) else begin
			$display("ack stayed high after a read from %h", addr);
			note_error();
		end
	endtask

	// 8N1 frame towards the dut, then a short idle gap
	task automatic drive_frame(input logic [7:0] b, input logic bad_stop);
		fpga_rxd = 1'b0;
		repeat (clks_per_bit) @(posedge clk);
		#1;
		for (int i = 0; i < 8; i++) begin
			fpga_rxd = b[i];
			repeat (clks_per_bit) @(posedge clk);
			#1;
		end
		fpga_rxd = !bad_stop;
		repeat (clks_per_bit) @(posedge clk);
		#1;
		fpga_rxd = 1'b1;
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic expect_frame(input logic [7:0] exp);
		int n;
		n = 0;
		while (tx_seen.size() == 0 && n < frame_timeout) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (tx_seen.size() != 0) else begin
			$display("no frame appeared on fpga_txd");
			note_error();
		end
		if (tx_seen.size() != 0)
			check_value("fpga_txd byte", {8'h0, tx_seen.pop_front()}, {8'h0, exp}, 16'hffff);
	endtask

	// decodes frames from fpga_txd at mid-bit
	initial begin : tx_monitor
		logic [7:0] b;
		logic       prev;
		prev = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			if (!rst && prev && !fpga_txd) begin
				repeat (half_bit) @(posedge clk);
				#1;
				assert (!fpga_txd) else begin
					$display("start bit on fpga_txd did not last to mid-bit");
					note_error();
				end
				for (int i = 0; i < 8; i++) begin
					repeat (clks_per_bit) @(posedge clk);
					#1;
					b[i] = fpga_txd;
				end
				repeat (clks_per_bit) @(posedge clk);
				#1;
				assert (fpga_txd) else begin
					$display("stop bit on fpga_txd was low");
					note_error();
				end
				tx_seen.push_back(b);
			end
			prev = fpga_txd;
		end
	end

	task automatic apply_step(input step_t s);
		logic [15:0] rd;
		case (s.op)
			op_write: host_write(s.addr, s.data);
			op_read: begin
				host_read(s.addr, rd);
				check_value($sformatf("host_rdata[%h]", s.addr), rd, s.exp, 16'hffff);
			end
			op_rx:    drive_frame(s.data[7:0], s.data[8]);
			op_tx:    expect_frame(s.exp[7:0]);
			op_state: bt_state = s.data[0];
			op_pins: begin
				check_value("bt_enable", {15'b0, bt_enable}, {15'b0, s.exp[0]}, 16'h1);
				check_value("fpga_txd", {15'b0, fpga_txd}, {15'b0, s.exp[1]}, 16'h1);
				check_value("led", {8'h0, led}, {8'h0, s.exp[15:8]}, 16'h00ff);
			end
			op_idle: begin
				repeat (s.data) @(posedge clk);
				#1;
			end
			default: begin
				checks++;
				assert (tx_seen.size() == 0) else begin
					$display("an extra frame appeared on fpga_txd");
					note_error();
				end
			end
		endcase
	endtask

	task automatic report_test(input int t);
		if (test_errors[t] == 0) begin
			$display("test %0d %s: passed", t, test_name[t]);
		end else begin
			$display("test %0d %s: %0d errors", t, test_name[t], test_errors[t]);
			failed_tests++;
		end
	endtask

	initial begin
		logic [7:0] txb;
		logic [7:0] rxb[14];
		rst        = 1'b1;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		bt_state   = 1'b1;
		fpga_rxd   = 1'b1;
		void'($urandom(32'h62a1));
		txb = 8'($urandom);
		for (int i = 0; i < 14; i++)
			rxb[i] = 8'($urandom);
		test_name = '{"after reset", "ctrl command", "send command", "receive", "errors and clear"};

		// after reset, state pin high
		build_test = 0;
		// state pin needs two flops to reach status
		add_step(op_idle, 0, 4, 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_bt_state_bit));
		add_step(op_read, ep_txcount_addr, 0, 0);
		add_step(op_read, ep_rxcount_addr, 0, 0);
		add_step(op_read, ep_rxdata_addr, 0, 0);
		add_step(op_read, 8'h05, 0, 0);
		add_step(op_pins, 0, 0, pins(1'b0, 1'b1, ~8'h01));
		add_step(op_state, 0, 0, 0);
		add_step(op_idle, 0, 4, 0);
		add_step(op_read, ep_status_addr, 0, 0);
		add_step(op_pins, 0, 0, pins(1'b0, 1'b1, 8'hff));

		// enable on, then off
		build_test = 1;
		add_step(op_write, ep_cmd_addr, {1'b1, 14'b0, 1'b1}, 0);
		// wire-in and trigger read back as zero
		add_step(op_read, ep_cmd_addr, 0, 0);
		add_step(op_write, ep_trig_addr, bitval(trig_exec_bit), 0);
		add_step(op_read, ep_trig_addr, 0, 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_enable_bit));
		add_step(op_pins, 0, 0, pins(1'b1, 1'b1, ~8'h02));
		add_step(op_write, ep_cmd_addr, {1'b1, 14'b0, 1'b0}, 0);
		add_step(op_write, ep_trig_addr, bitval(trig_exec_bit), 0);
		add_step(op_read, ep_status_addr, 0, 0);
		add_step(op_pins, 0, 0, pins(1'b0, 1'b1, 8'hff));

		// second exec lands while the frame is still going
		build_test = 2;
		add_step(op_write, ep_cmd_addr, {1'b0, 7'b0, txb}, 0);
		add_step(op_write, ep_trig_addr, bitval(trig_exec_bit), 0);
		add_step(op_write, ep_trig_addr, bitval(trig_exec_bit), 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_tx_busy_bit) | bitval(st_tx_overrun_bit));
		add_step(op_read, ep_txcount_addr, 0, 1);
		add_step(op_tx, 0, 0, {8'h0, txb});
		// long enough for a whole second frame to show up
		add_step(op_idle, 0, 12 * clks_per_bit, 0);
		add_step(op_tx_none, 0, 0, 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_tx_overrun_bit));
		add_step(op_read, ep_txcount_addr, 0, 1);
		add_step(op_write, ep_trig_addr, bitval(trig_clear_bit), 0);
		add_step(op_read, ep_status_addr, 0, 0);

		build_test = 3;
		for (int i = 0; i < n_rx; i++)
			add_step(op_rx, 0, {8'h0, rxb[i]}, 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_rx_avail_bit) | 16'(n_rx << 8));
		add_step(op_read, ep_rxcount_addr, 0, 16'(n_rx));
		for (int i = 0; i < n_rx; i++) begin
			add_step(op_read, ep_rxdata_addr, 0, {7'b0, 1'b1, rxb[i]});
			add_step(op_write, ep_trig_addr, bitval(trig_pop_bit), 0);
		end
		add_step(op_read, ep_status_addr, 0, 0);
		// pop with nothing queued
		add_step(op_write, ep_trig_addr, bitval(trig_pop_bit), 0);
		add_step(op_read, ep_status_addr, 0, 0);
		add_step(op_read, ep_rxdata_addr, 0, 0);

		// one byte more than the queue holds
		build_test = 4;
		for (int i = 0; i <= rxq_depth; i++)
			add_step(op_rx, 0, {8'h0, rxb[n_rx + i]}, 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_rx_avail_bit) |
			bitval(st_rx_overflow_bit) | 16'(rxq_depth << 8));
		add_step(op_read, ep_rxcount_addr, 0, 16'(n_rx + rxq_depth));
		for (int i = 0; i < rxq_depth; i++) begin
			add_step(op_read, ep_rxdata_addr, 0, {7'b0, 1'b1, rxb[n_rx + i]});
			add_step(op_write, ep_trig_addr, bitval(trig_pop_bit), 0);
		end
		add_step(op_rx, 0, {7'b0, 1'b1, txb}, 0);
		add_step(op_read, ep_status_addr, 0, bitval(st_rx_overflow_bit) | bitval(st_frame_err_bit));
		add_step(op_read, ep_rxdata_addr, 0, 0);
		add_step(op_read, ep_rxcount_addr, 0, 16'(n_rx + rxq_depth));
		add_step(op_write, ep_trig_addr, bitval(trig_clear_bit), 0);
		add_step(op_read, ep_status_addr, 0, 0);
		add_step(op_read, ep_txcount_addr, 0, 1);
		add_step(op_read, ep_rxcount_addr, 0, 16'(n_rx + rxq_depth));

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		cur_test = 0;
		for (int i = 0; i < steps.size(); i++) begin
			if (steps[i].test != cur_test) begin
				report_test(cur_test);
				cur_test = steps[i].test;
			end
			apply_step(steps[i]);
		end
		report_test(cur_test);
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors", cur_test + 1,
			failed_tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* files.f */
fbc_cfg_pkg.sv
fbc_cmd_pkg.sv
uart_tx.sv
uart_rx.sv
bt_link_ctrl.sv
host_endpoints.sv
fbc_top.sv
tb_fbc.sv

/* Bender.yml */
package:
  name: fbc_bt_link

sources:
  - fbc_cfg_pkg.sv
  - fbc_cmd_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - bt_link_ctrl.sv
  - host_endpoints.sv
  - fbc_top.sv
  - target: simulation
    files:
      - tb_fbc.sv
